// ==== source/clic_consts.svh ====
// CLIC constants
`ifndef CLIC_CONSTS_SVH
`define CLIC_CONSTS_SVH

// vector table geometry
`define CLIC_VEC_SIZE 8
`define CLIC_PRIO_LEVELS 8

// datapath widths
`define CLIC_WORD_W 32
`define CLIC_CSR_ADDR_W 12
// vector CSR holds a word address, so two bits fewer
`define CLIC_IMEM_ADDR_W 16

// per-vector CSR bases, room for 32 vectors each
`define CLIC_VEC_CSR_BASE 'hb00
`define CLIC_ENTRY_CSR_BASE 'hb20

// global CSRs
`define CLIC_MSTATUS_ADDR 'h300
`define CLIC_MINTTHRESH_ADDR 'h347
`define CLIC_STACKDEPTH_ADDR 'h350

// global interrupt enable in mstatus
`define CLIC_MIE_BIT 3

// reset values of the global CSRs
`define CLIC_MSTATUS_RESET 0
`define CLIC_MINTTHRESH_RESET 0

`endif

// ==== source/clic_pkg.sv ====
// CLIC shared types
`include "clic_consts.svh"

package clic_pkg;

  typedef logic [`CLIC_WORD_W-1:0] wordT;
  typedef logic [`CLIC_CSR_ADDR_W-1:0] csrAddrT;
  // Zicsr immediate field
  typedef logic [4:0] zimmT;
  typedef logic [$clog2(`CLIC_PRIO_LEVELS)-1:0] prioT;
  typedef logic [$clog2(`CLIC_VEC_SIZE)-1:0] vecIdxT;
  // one bit per vector
  typedef logic [`CLIC_VEC_SIZE-1:0] vecMaskT;

  typedef enum logic [2:0] {
    csrNone,
    csrRw,
    csrRs,
    csrRc,
    csrRwi,
    csrRsi,
    csrRci
  } csrOpT;

  // 5 bits, fits the immediate
  typedef struct packed {
    logic pended;
    logic enable;
    prioT prio;
  } entryT;

  // Zicsr update of one register
  function automatic wordT csrNext(wordT cur, csrOpT op, zimmT zimm, wordT rs1);
    wordT operand;
    // immediate forms zero-extend
    operand = (op inside {csrRwi, csrRsi, csrRci}) ? wordT'(zimm) : rs1;
    case (op)
      csrRw, csrRwi: csrNext = operand;
      csrRs, csrRsi: csrNext = cur | operand;
      csrRc, csrRci: csrNext = cur & ~operand;
      default: csrNext = cur;
    endcase
  endfunction

endpackage

// ==== source/csrReg.sv ====
// generic CSR
`timescale 1ns/1ps
`include "clic_consts.svh"

module csrReg
  import clic_pkg::*;
#(
  parameter int Width = `CLIC_WORD_W,
  parameter csrAddrT Addr = '0,
  parameter logic [Width-1:0] ResetValue = '0,
  // zero makes it read-only
  parameter bit Writable = 1'b1
) (
  input logic clk,
  input logic rstN,
  input logic csrEnable,
  input csrAddrT csrAddr,
  input csrOpT csrOp,
  input zimmT rs1Zimm,
  input wordT rs1Data,
  output wordT rdata,
  output logic [Width-1:0] data
);

  logic hit;
  logic doWrite;
  wordT nextWord;

  // own address decode
  assign hit = (csrAddr == Addr);
  assign doWrite = Writable && csrEnable && hit && (csrOp != csrNone);

  // full-word update with upper bits dropped on store
  assign nextWord = csrNext(wordT'(data), csrOp, rs1Zimm, rs1Data);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      data <= ResetValue;
    end else if (doWrite) begin
      data <= nextWord[Width-1:0];
    end
  end

  // zero when not addressed so the top can OR
  assign rdata = hit ? wordT'(data) : '0;

endmodule

// ==== source/clicEntryTable.sv ====
// CLIC vector and entry table
`timescale 1ns/1ps
`include "clic_consts.svh"

module clicEntryTable
  import clic_pkg::*;
(
  input logic clk,
  input logic rstN,
  input logic csrEnable,
  input csrAddrT csrAddr,
  input csrOpT csrOp,
  input zimmT rs1Zimm,
  input wordT rs1Data,
  input vecMaskT irqLines,
  input logic ackStrobe,
  input vecIdxT ackIndex,
  output wordT rdata,
  output entryT entries [`CLIC_VEC_SIZE],
  output wordT vectors [`CLIC_VEC_SIZE]
);

  localparam int VecW = `CLIC_IMEM_ADDR_W - 2;

  wordT vecRdata [`CLIC_VEC_SIZE];
  logic [VecW-1:0] vecData [`CLIC_VEC_SIZE];
  entryT entryQ [`CLIC_VEC_SIZE];
  entryT entryNext [`CLIC_VEC_SIZE];

  // vector address CSRs, plain software registers
  for (genvar k = 0; k < `CLIC_VEC_SIZE; k++) begin : genVec
    csrReg #(
      .Width(VecW),
      .Addr(csrAddrT'(`CLIC_VEC_CSR_BASE + k)),
      .ResetValue('0),
      .Writable(1'b1)
    ) i_vecCsr (
      .*,
      .rdata(vecRdata[k]),
      .data(vecData[k])
    );
    assign vectors[k] = wordT'(vecData[k]);
  end

  // entry next state
  always_comb begin
    wordT upd;
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      entryNext[k] = entryQ[k];
      upd = csrNext(wordT'(entryQ[k]), csrOp, rs1Zimm, rs1Data);
      // software write first
      if (csrEnable && csrOp != csrNone &&
          csrAddr == csrAddrT'(`CLIC_ENTRY_CSR_BASE + k)) begin
        entryNext[k] = upd[$bits(entryT)-1:0];
      end
      // then ack clear
      if (ackStrobe && ackIndex == vecIdxT'(k)) begin
        entryNext[k].pended = 1'b0;
      end
      // a live line always wins
      if (irqLines[k]) begin
        entryNext[k].pended = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
        entryQ[k] <= '0;
      end
    end else begin
      entryQ <= entryNext;
    end
  end

  assign entries = entryQ;

  // read OR of both CSR banks
  always_comb begin
    rdata = '0;
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      rdata = rdata | vecRdata[k];
      if (csrAddr == csrAddrT'(`CLIC_ENTRY_CSR_BASE + k)) begin
        rdata = rdata | wordT'(entryQ[k]);
      end
    end
  end

  // the top only acks a pended winner
  ackPended: assert property (
    @(posedge clk) disable iff (!rstN)
    ackStrobe |-> entryQ[ackIndex].pended
  );

endmodule

// ==== source/prioArbiter.sv ====
// CLIC priority arbiter
`timescale 1ns/1ps
`include "clic_consts.svh"

module prioArbiter
  import clic_pkg::*;
(
  input entryT entries [`CLIC_VEC_SIZE],
  input prioT threshold,
  output logic winValid,
  output vecIdxT winIndex
);

  // running best starts at threshold and must be beaten
  prioT bestPrio;

  always_comb begin
    winValid = 1'b0;
    winIndex = '0;
    bestPrio = threshold;
    // strict compare keeps the lowest index on a tie
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      if (entries[k].enable && entries[k].pended &&
          entries[k].prio > bestPrio) begin
        winValid = 1'b1;
        winIndex = vecIdxT'(k);
        bestPrio = entries[k].prio;
      end
    end
  end

endmodule

// ==== source/nClic.sv ====
// CLIC top level
`timescale 1ns/1ps
`include "clic_consts.svh"

module nClic
  import clic_pkg::*;
(
  input logic clk,
  input logic rstN,
  input logic csrEnable,
  input csrAddrT csrAddr,
  input csrOpT csrOp,
  input zimmT rs1Zimm,
  input wordT rs1Data,
  input vecMaskT irqLines,
  input logic irqAck,
  input logic irqRet,
  output wordT csrRdata,
  output logic takeInterrupt,
  output vecIdxT intIndex,
  output wordT intVector
);

  // depth can reach the vector count, one extra bit
  localparam int DepthW = $clog2(`CLIC_VEC_SIZE + 1);

  wordT mstatus;
  wordT mstatusRdata;
  prioT threshold;
  wordT threshRdata;
  wordT tableRdata;
  wordT depthRdata;
  entryT entries [`CLIC_VEC_SIZE];
  wordT vectors [`CLIC_VEC_SIZE];
  logic winValid;
  logic ackStrobe;
  logic [DepthW-1:0] stackDepth;

  // mstatus, only MIE matters here
  csrReg #(
    .Width(`CLIC_WORD_W),
    .Addr(csrAddrT'(`CLIC_MSTATUS_ADDR)),
    .ResetValue(`CLIC_MSTATUS_RESET),
    .Writable(1'b1)
  ) i_mstatus (
    .*,
    .rdata(mstatusRdata),
    .data(mstatus)
  );

  // mintthresh, priority wide
  csrReg #(
    .Width($bits(prioT)),
    .Addr(csrAddrT'(`CLIC_MINTTHRESH_ADDR)),
    .ResetValue(`CLIC_MINTTHRESH_RESET),
    .Writable(1'b1)
  ) i_mintthresh (
    .*,
    .rdata(threshRdata),
    .data(threshold)
  );

  clicEntryTable i_entryTable (
    .*,
    .ackIndex(intIndex),
    .rdata(tableRdata)
  );

  prioArbiter i_arbiter (
    .*,
    .winIndex(intIndex)
  );

  // global enable gate
  assign takeInterrupt = winValid & mstatus[`CLIC_MIE_BIT];
  assign intVector = vectors[intIndex];
  // stray acks dropped
  assign ackStrobe = irqAck & takeInterrupt;

  // nesting depth, ack pushes, return pops
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stackDepth <= '0;
    end else if (ackStrobe && !irqRet) begin
      stackDepth <= stackDepth + 1'b1;
    end else if (irqRet && !ackStrobe && stackDepth != '0) begin
      // saturate at zero
      stackDepth <= stackDepth - 1'b1;
    end
  end

  // read-only decode, writes fall through unseen
  assign depthRdata = (csrAddr == csrAddrT'(`CLIC_STACKDEPTH_ADDR)) ?
                      wordT'(stackDepth) : '0;

  // unmapped addresses read zero
  assign csrRdata = mstatusRdata | threshRdata | tableRdata | depthRdata;

  // no preemption, so nesting is bounded by the vectors
  depthBound: assert property (
    @(posedge clk) disable iff (!rstN)
    stackDepth <= DepthW'(`CLIC_VEC_SIZE)
  );

endmodule

// ==== testbench/tbNClic.sv ====
// nClic testbench
`timescale 1ns/1ps
`include "clic_consts.svh"

module tbNClic
  import clic_pkg::*;
();

  logic clk;
  logic rstN;
  logic csrEnable;
  csrAddrT csrAddr;
  csrOpT csrOp;
  zimmT rs1Zimm;
  wordT rs1Data;
  vecMaskT irqLines;
  logic irqAck;
  logic irqRet;
  wordT csrRdata;
  logic takeInterrupt;
  vecIdxT intIndex;
  wordT intVector;

  // one stimulus row and what the outputs must show after its edge
  typedef struct packed {
    csrOpT op;
    csrAddrT addr;
    wordT operand;
    vecMaskT irq;
    logic ack;
    logic ret;
    wordT expRdata;
    logic expTake;
    vecIdxT expIndex;
    wordT expVector;
  } rowT;

  localparam csrAddrT MstAddr = csrAddrT'(`CLIC_MSTATUS_ADDR);
  localparam csrAddrT ThAddr = csrAddrT'(`CLIC_MINTTHRESH_ADDR);
  localparam csrAddrT SdAddr = csrAddrT'(`CLIC_STACKDEPTH_ADDR);

  rowT rows[$];
  string names[$];
  // reference state after the last queued row
  entryT mEnt [`CLIC_VEC_SIZE];
  wordT mVec [`CLIC_VEC_SIZE];
  prioT mThresh;
  logic mMie;
  int mDepth;
  int errors;
  int failedTests;

  nClic i_nClic (.*);

  always #10 clk = ~clk;

  // reset low for 8 cycles and released on a falling edge
  initial begin
    rstN = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

  function automatic csrAddrT vecAddr(input int k);
    return csrAddrT'(`CLIC_VEC_CSR_BASE + k);
  endfunction

  function automatic csrAddrT entAddr(input int k);
    return csrAddrT'(`CLIC_ENTRY_CSR_BASE + k);
  endfunction

  // arbitration rule on the reference state
  function automatic logic modelWinner(output vecIdxT idx);
    int best;
    best = -1;
    idx = '0;
    // highest priority among enabled and pended vectors above threshold
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      if (mEnt[k].enable && mEnt[k].pended && mEnt[k].prio > mThresh &&
          int'(mEnt[k].prio) > best) begin
        best = int'(mEnt[k].prio);
      end
    end
    // lowest index holding that priority
    for (int k = `CLIC_VEC_SIZE - 1; k >= 0; k--) begin
      if (mEnt[k].enable && mEnt[k].pended && int'(mEnt[k].prio) == best) begin
        idx = vecIdxT'(k);
      end
    end
    return (best >= 0) && mMie;
  endfunction

  task automatic addRow(input string name, input csrOpT op, input csrAddrT addr,
                        input wordT operand, input vecMaskT irq, input logic ack,
                        input logic ret, input wordT expRdata);
    rowT r;
    vecIdxT w;
    r = '{op, addr, operand, irq, ack, ret, expRdata, 1'b0, '0, '0};
    r.expTake = modelWinner(w);
    r.expIndex = w;
    r.expVector = mVec[w];
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic csrRow(input string name, input csrOpT op, input csrAddrT addr,
                        input wordT operand, input wordT expRdata);
    addRow(name, op, addr, operand, '0, 1'b0, 1'b0, expRdata);
  endtask

  task automatic pendLines(input string name, input vecMaskT lines);
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      if (lines[k]) mEnt[k].pended = 1'b1;
    end
    addRow(name, csrNone, SdAddr, '0, lines, 1'b0, 1'b0, wordT'(mDepth));
  endtask

  task automatic buildTable();
    vecIdxT w;
    wordT v;
    int n;
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      mEnt[k] = '0;
      mVec[k] = '0;
    end
    mThresh = '0;
    mMie = 1'b0;
    mDepth = 0;
    // everything zero out of reset
    csrRow("reset mstatus", csrNone, MstAddr, '0, '0);
    csrRow("reset mintthresh", csrNone, ThAddr, '0, '0);
    csrRow("reset stack depth", csrNone, SdAddr, '0, '0);
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      csrRow("reset vector", csrNone, vecAddr(k), '0, '0);
      csrRow("reset entry", csrNone, entAddr(k), '0, '0);
    end
    csrRow("unmapped read", csrNone, 12'h123, '0, '0);
    // threshold is 3 bits wide so upper operand bits drop
    csrRow("mintthresh rw", csrRw, ThAddr, 32'hffff_fff5, 32'h5);
    csrRow("mintthresh rs", csrRs, ThAddr, 32'h2, 32'h7);
    csrRow("mintthresh rc", csrRc, ThAddr, 32'h6, 32'h1);
    csrRow("mintthresh rwi", csrRwi, ThAddr, 32'h3, 32'h3);
    csrRow("mintthresh rsi", csrRsi, ThAddr, 32'h4, 32'h7);
    csrRow("mintthresh rci", csrRci, ThAddr, 32'h7, 32'h0);
    // MIE comes up on the rsi row while nothing is pended
    csrRow("mstatus rw", csrRw, MstAddr, 32'h1234_5670, 32'h1234_5670);
    csrRow("mstatus rc", csrRc, MstAddr, 32'hffff_0000, 32'h5670);
    csrRow("mstatus rsi", csrRsi, MstAddr, 32'hffff_ffe8, 32'h5678);
    csrRow("mstatus rci", csrRci, MstAddr, 32'h10, 32'h5668);
    csrRow("mstatus clear", csrRw, MstAddr, '0, '0);
    // 14-bit word address
    csrRow("vector rw", csrRw, vecAddr(3), 32'hffff_abcd, 32'h2bcd);
    csrRow("vector rci", csrRci, vecAddr(3), 32'h0d, 32'h2bc0);
    csrRow("vector rs", csrRs, vecAddr(3), 32'h3, 32'h2bc3);
    csrRow("vector rc", csrRc, vecAddr(3), 32'hffff_ffff, '0);
    // pended and enabled by software while MIE is low
    csrRow("entry rwi", csrRwi, entAddr(2), 32'h1b, 32'h1b);
    csrRow("entry rci", csrRci, entAddr(2), 32'h10, 32'h0b);
    csrRow("entry rw", csrRw, entAddr(2), 32'hffff_ffff, 32'h1f);
    csrRow("entry rc", csrRc, entAddr(2), 32'hffff_ffff, '0);
    csrRow("stack depth rw", csrRw, SdAddr, 32'h5, '0);
    csrRow("stack depth rsi", csrRsi, SdAddr, 32'h1f, '0);
    // arbitration setup with vector 5 left disabled
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      v = wordT'('h100 + 'h40 * k);
      mVec[k] = v;
      csrRow("vector setup", csrRw, vecAddr(k), v, v);
    end
    mThresh = prioT'(1);
    csrRow("threshold one", csrRwi, ThAddr, 32'h1, 32'h1);
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      mEnt[k].enable = (k != 5);
      mEnt[k].prio = prioT'($urandom % `CLIC_PRIO_LEVELS);
      csrRow("entry random prio", csrRw, entAddr(k), wordT'(mEnt[k]), wordT'(mEnt[k]));
    end
    mMie = 1'b1;
    csrRow("mie set", csrRsi, MstAddr, 32'h8, 32'h8);
    pendLines("pend lines a5", 8'ha5);
    pendLines("pend lines 5a", 8'h5a);
    // two vectors tied at the top level
    mEnt[6] = '{1'b1, 1'b1, 3'd7};
    csrRow("entry 6 top prio", csrRw, entAddr(6), 32'h1f, 32'h1f);
    mEnt[1] = '{1'b1, 1'b1, 3'd7};
    csrRow("entry 1 top prio", csrRw, entAddr(1), 32'h1f, 32'h1f);
    // masking by threshold and by MIE
    mThresh = prioT'(7);
    csrRow("threshold at winner", csrRw, ThAddr, 32'h7, 32'h7);
    mThresh = prioT'(6);
    csrRow("threshold below winner", csrRw, ThAddr, 32'h6, 32'h6);
    mMie = 1'b0;
    csrRow("mie clear", csrRci, MstAddr, 32'h8, '0);
    mMie = 1'b1;
    csrRow("mie restore", csrRsi, MstAddr, 32'h8, 32'h8);
    mThresh = '0;
    csrRow("threshold zero", csrRci, ThAddr, 32'h7, '0);
    // ack every winner in turn and read its entry back
    for (int i = 0; i < `CLIC_VEC_SIZE; i++) begin
      if (modelWinner(w)) begin
        mEnt[w].pended = 1'b0;
        mDepth++;
        addRow("ack winner", csrNone, entAddr(w), '0, '0, 1'b1, 1'b0, wordT'(mEnt[w]));
      end
    end
    csrRow("depth after acks", csrNone, SdAddr, '0, wordT'(mDepth));
    addRow("stray ack", csrNone, SdAddr, '0, '0, 1'b1, 1'b0, wordT'(mDepth));
    // one return more than needed so depth stops at zero
    n = mDepth + 1;
    for (int i = 0; i < n; i++) begin
      if (mDepth > 0) mDepth--;
      addRow("return", csrNone, SdAddr, '0, '0, 1'b0, 1'b1, wordT'(mDepth));
    end
  endtask

  task automatic applyRow(input rowT r);
    logic isImm;
    isImm = r.op inside {csrRwi, csrRsi, csrRci};
    csrEnable = (r.op != csrNone);
    csrOp = r.op;
    csrAddr = r.addr;
    rs1Zimm = r.operand[4:0];
    // rs1Data carries junk on immediate ops
    rs1Data = isImm ? ~r.operand : r.operand;
    irqLines = r.irq;
    irqAck = r.ack;
    irqRet = r.ret;
  endtask

  task automatic checkWord(input string name, input wordT got, input wordT exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkTake(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkIndex(input string name, input vecIdxT got, input vecIdxT exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  initial begin
    int waitCycles;
    int errorsBefore;
    rowT r;
    clk = 1'b0;
    csrEnable = 1'b0;
    csrAddr = '0;
    csrOp = csrNone;
    rs1Zimm = '0;
    rs1Data = '0;
    irqLines = '0;
    irqAck = 1'b0;
    irqRet = 1'b0;
    errors = 0;
    failedTests = 0;
    void'($urandom(74));
    buildTable();
    waitCycles = 0;
    while (rstN !== 1'b1 && waitCycles < 50) begin
      @(negedge clk);
      waitCycles++;
    end
    if (rstN !== 1'b1) begin
      $display("timeout: reset was not released within 50 cycles");
      $display("TEST RESULT: FAIL");
    end else begin
      // drive on the falling edge and sample one falling edge later
      for (int i = 0; i < rows.size(); i++) begin
        r = rows[i];
        errorsBefore = errors;
        applyRow(r);
        @(posedge clk);
        @(negedge clk);
        checkWord("csrRdata", csrRdata, r.expRdata);
        checkTake("takeInterrupt", takeInterrupt, r.expTake);
        if (r.expTake) begin
          checkIndex("intIndex", intIndex, r.expIndex);
          checkWord("intVector", intVector, r.expVector);
        end
        if (errors == errorsBefore) begin
          $display("test %0d %s: ok", i, names[i]);
        end else begin
          $display("test %0d %s: failed", i, names[i]);
          failedTests++;
        end
      end
      $display("%0d tests, %0d passed, %0d failed", rows.size(), rows.size() - failedTests,
               failedTests);
      if (failedTests == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+source
source/clic_pkg.sv
source/csrReg.sv
source/clicEntryTable.sv
source/prioArbiter.sv
source/nClic.sv
testbench/tbNClic.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbNClic -f filelist.f

out=$(./obj_dir/VtbNClic 2>&1) || { printf '%s\n' "$out"; exit 1; }
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TEST RESULT: PASS'; then
  exit 0
fi
exit 1
